// File: logic/riscvPipe_macros.svh
/*
 * RV32I pipeline sizing
 * Word width, register count and reset PC shared by the core
 */

`ifndef RISCVPIPE_MACROS_SVH
`define RISCVPIPE_MACROS_SVH

// Data and address width of the core
`define XLEN 32

// Architectural integer registers, x0 included
`define NREGS 32

// First fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// File: logic/riscvPipe_pkg.sv
/*
 * RV32I pipeline types
 * Opcode and control encodings plus the structs passed between
 * controller and datapath
 */

`default_nettype none

package riscvPipe_pkg;

    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,
        OP_IMM    = 7'b0010011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_AND = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLT = 3'b100
    } aluOp_e;

    typedef enum logic [1:0] {IMM_I, IMM_S, IMM_B, IMM_J} immSrc_e;

    typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} resultSrc_e;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,
        FWD_WB  = 2'b01,
        FWD_MEM = 2'b10
    } forward_e;

    // Fields the controller needs from the datapath
    typedef struct packed {
        opcode_e    opcode;
        logic [2:0] funct3;
        logic       funct7b5;
        logic [4:0] rs1D;
        logic [4:0] rs2D;
        logic [4:0] rs1E;
        logic [4:0] rs2E;
        logic [4:0] rdE;
        logic [4:0] rdM;
        logic [4:0] rdW;
    } decodeInfo_t;

    typedef struct packed {
        immSrc_e    immSrcD;
        aluOp_e     aluOpE;
        logic       aluSrcE;     // Immediate as ALU operand B
        logic       branchE;
        logic       branchNeE;   // bne rather than beq
        logic       jumpE;
        resultSrc_e resultSrcM;
        logic       memWriteM;
        logic       regWriteW;
        resultSrc_e resultSrcW;
    } stageCtl_t;

    typedef struct packed {
        logic     stallF;
        logic     stallD;
        logic     flushD;
        logic     flushE;
        forward_e forwardAE;
        forward_e forwardBE;
    } hazardCtl_t;

endpackage

`default_nettype wire

// File: logic/riscvRegFile.sv
/*
 * Integer register file
 * Two read ports, one write port, x0 hardwired to zero and
 * same-cycle write data returned on reads
 */

`default_nettype none

`include "riscvPipe_macros.svh"

module riscvRegFile (
    input  wire logic                       clk,
    input  wire logic                       arstN_i,
    input  wire logic [$clog2(`NREGS)-1:0]  rs1Addr_i,
    input  wire logic [$clog2(`NREGS)-1:0]  rs2Addr_i,
    input  wire logic [$clog2(`NREGS)-1:0]  rdAddr_i,
    input  wire logic [`XLEN-1:0]           rdData_i,
    input  wire logic                       we_i,
    output logic      [`XLEN-1:0]           rs1Data_o,
    output logic      [`XLEN-1:0]           rs2Data_o
);

    logic [`XLEN-1:0] regs [1:`NREGS-1];  // No storage behind x0

    function automatic logic [`XLEN-1:0] readPort(input logic [$clog2(`NREGS)-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (we_i && (addr == rdAddr_i)) begin
            return rdData_i;  // Write-through
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 1; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && (rdAddr_i != '0)) begin
            regs[rdAddr_i] <= rdData_i;
        end
    end

    always_comb begin
        rs1Data_o = readPort(rs1Addr_i);
        rs2Data_o = readPort(rs2Addr_i);
    end

endmodule

`default_nettype wire

// File: logic/riscvPipeController.sv
/*
 * Pipeline controller
 * Decodes instructions, carries control down to writeback and
 * resolves forwarding, load-use, fetch-ready and mispredict hazards
 */

`default_nettype none

module riscvPipeController (
    input  wire logic                        clk,
    input  wire logic                        arstN_i,
    input  wire riscvPipe_pkg::decodeInfo_t  decodeInfo_i,
    input  wire logic                        mispredictE_i,
    input  wire logic                        readyF_i,
    output riscvPipe_pkg::stageCtl_t         stageCtl_o,
    output riscvPipe_pkg::hazardCtl_t        hazardCtl_o
);

    // Control consumed in execute and later
    typedef struct packed {
        logic                      regWrite;
        riscvPipe_pkg::resultSrc_e resultSrc;
        logic                      memWrite;
        logic                      branch;
        logic                      branchNe;
        logic                      jump;
        riscvPipe_pkg::aluOp_e     aluOp;
        logic                      aluSrc;
    } exCtl_t;

    exCtl_t                    ctlD;
    exCtl_t                    ctlE;
    riscvPipe_pkg::immSrc_e    immSrcD;
    logic                      regWriteM;
    riscvPipe_pkg::resultSrc_e resultSrcM;
    logic                      memWriteM;
    logic                      regWriteW;
    riscvPipe_pkg::resultSrc_e resultSrcW;
    logic                      lwStall;

    function automatic riscvPipe_pkg::aluOp_e aluFromFunct(input logic [2:0] funct3,
                                                           input logic       isSub);
        case (funct3)
            3'b000:  return isSub ? riscvPipe_pkg::ALU_SUB : riscvPipe_pkg::ALU_ADD;
            3'b010:  return riscvPipe_pkg::ALU_SLT;
            3'b110:  return riscvPipe_pkg::ALU_OR;
            3'b111:  return riscvPipe_pkg::ALU_AND;
            default: return riscvPipe_pkg::ALU_ADD;
        endcase
    endfunction

    // Highest priority to the youngest producer
    function automatic riscvPipe_pkg::forward_e fwdSel(input logic [4:0] rs);
        if ((rs != '0) && (rs == decodeInfo_i.rdM) && regWriteM) begin
            return riscvPipe_pkg::FWD_MEM;
        end
        if ((rs != '0) && (rs == decodeInfo_i.rdW) && regWriteW) begin
            return riscvPipe_pkg::FWD_WB;
        end
        return riscvPipe_pkg::FWD_REG;
    endfunction

    // Main decoder, unknown opcodes become bubbles
    always_comb begin
        ctlD    = '0;
        immSrcD = riscvPipe_pkg::IMM_I;
        case (decodeInfo_i.opcode)
            riscvPipe_pkg::OP_R: begin
                ctlD.regWrite = 1'b1;
                ctlD.aluOp    = aluFromFunct(decodeInfo_i.funct3, decodeInfo_i.funct7b5);
            end
            riscvPipe_pkg::OP_IMM: begin
                ctlD.regWrite = 1'b1;
                ctlD.aluSrc   = 1'b1;
                ctlD.aluOp    = aluFromFunct(decodeInfo_i.funct3, 1'b0);  // No subi
            end
            riscvPipe_pkg::OP_LOAD: begin
                ctlD.regWrite  = 1'b1;
                ctlD.aluSrc    = 1'b1;
                ctlD.resultSrc = riscvPipe_pkg::RES_MEM;
            end
            riscvPipe_pkg::OP_STORE: begin
                ctlD.memWrite = 1'b1;
                ctlD.aluSrc   = 1'b1;
                immSrcD       = riscvPipe_pkg::IMM_S;
            end
            riscvPipe_pkg::OP_BRANCH: begin
                ctlD.branch   = 1'b1;
                ctlD.branchNe = decodeInfo_i.funct3[0];  // 000 beq, 001 bne
                immSrcD       = riscvPipe_pkg::IMM_B;
            end
            riscvPipe_pkg::OP_JAL: begin
                ctlD.regWrite  = 1'b1;
                ctlD.jump      = 1'b1;
                ctlD.resultSrc = riscvPipe_pkg::RES_PC4;
                immSrcD        = riscvPipe_pkg::IMM_J;
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            ctlE       <= '0;
            regWriteM  <= 1'b0;
            resultSrcM <= riscvPipe_pkg::RES_ALU;
            memWriteM  <= 1'b0;
            regWriteW  <= 1'b0;
            resultSrcW <= riscvPipe_pkg::RES_ALU;
        end else begin
            ctlE       <= hazardCtl_o.flushE ? '0 : ctlD;
            regWriteM  <= ctlE.regWrite;
            resultSrcM <= ctlE.resultSrc;
            memWriteM  <= ctlE.memWrite;
            regWriteW  <= regWriteM;
            resultSrcW <= resultSrcM;
        end
    end

    // Load in execute feeding the instruction in decode
    assign lwStall = (ctlE.resultSrc == riscvPipe_pkg::RES_MEM) &&
                     ((decodeInfo_i.rdE == decodeInfo_i.rs1D) ||
                      (decodeInfo_i.rdE == decodeInfo_i.rs2D));

    always_comb begin
        hazardCtl_o.stallF    = (lwStall || !readyF_i) && !mispredictE_i;
        hazardCtl_o.stallD    = lwStall && !mispredictE_i;
        hazardCtl_o.flushD    = mispredictE_i || (!readyF_i && !lwStall);  // Fetch bubble
        hazardCtl_o.flushE    = mispredictE_i || lwStall;
        hazardCtl_o.forwardAE = fwdSel(decodeInfo_i.rs1E);
        hazardCtl_o.forwardBE = fwdSel(decodeInfo_i.rs2E);
    end

    always_comb begin
        stageCtl_o.immSrcD    = immSrcD;
        stageCtl_o.aluOpE     = ctlE.aluOp;
        stageCtl_o.aluSrcE    = ctlE.aluSrc;
        stageCtl_o.branchE    = ctlE.branch;
        stageCtl_o.branchNeE  = ctlE.branchNe;
        stageCtl_o.jumpE      = ctlE.jump;
        stageCtl_o.resultSrcM = resultSrcM;
        stageCtl_o.memWriteM  = memWriteM;
        stageCtl_o.regWriteW  = regWriteW;
        stageCtl_o.resultSrcW = resultSrcW;
    end

endmodule

`default_nettype wire

// File: logic/riscvPipeDatapath.sv
/*
 * Pipeline datapath
 * PC, stage data registers, immediates, ALU with forwarding,
 * branch resolution and writeback select
 */

`default_nettype none

`include "riscvPipe_macros.svh"

module riscvPipeDatapath (
    input  wire logic                       clk,
    input  wire logic                       arstN_i,
    input  wire logic [`XLEN-1:0]           instrF_i,
    input  wire logic [`XLEN-1:0]           readDataM_i,
    input  wire riscvPipe_pkg::stageCtl_t   stageCtl_i,
    input  wire riscvPipe_pkg::hazardCtl_t  hazardCtl_i,
    output logic      [`XLEN-1:0]           pcF_o,
    output riscvPipe_pkg::decodeInfo_t      decodeInfo_o,
    output logic                            mispredictE_o,
    output logic      [`XLEN-1:0]           aluResultM_o,
    output logic      [`XLEN-1:0]           writeDataM_o
);

    typedef struct packed {
        logic [`XLEN-1:0] instr;
        logic [`XLEN-1:0] pc;
    } fdReg_t;

    typedef struct packed {
        logic [`XLEN-1:0] rd1;
        logic [`XLEN-1:0] rd2;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
    } deReg_t;

    typedef struct packed {
        logic [`XLEN-1:0] aluResult;
        logic [`XLEN-1:0] data;       // Store data in M, load data in W
        logic [`XLEN-1:0] pcPlus4;
        logic [4:0]       rd;
    } memReg_t;

    logic [`XLEN-1:0] pcF;
    logic [`XLEN-1:0] pcNextF;
    fdReg_t           fd;
    deReg_t           de;
    deReg_t           deNext;
    memReg_t          em;
    memReg_t          mw;
    logic [`XLEN-1:0] rd1D;
    logic [`XLEN-1:0] rd2D;
    logic [`XLEN-1:0] srcAE;
    logic [`XLEN-1:0] srcBE;
    logic [`XLEN-1:0] writeDataE;
    logic [`XLEN-1:0] aluResultE;
    logic [`XLEN-1:0] pcTargetE;
    logic [`XLEN-1:0] fwdValueM;
    logic [`XLEN-1:0] resultW;
    logic             takenE;

    function automatic logic [`XLEN-1:0] fwdMux(input riscvPipe_pkg::forward_e sel,
                                                input logic [`XLEN-1:0]     regVal,
                                                input logic [`XLEN-1:0]     wbVal,
                                                input logic [`XLEN-1:0]     memVal);
        case (sel)
            riscvPipe_pkg::FWD_MEM: return memVal;
            riscvPipe_pkg::FWD_WB:  return wbVal;
            default:                return regVal;
        endcase
    endfunction

    // Fetch
    assign pcNextF = mispredictE_o ? pcTargetE : pcF + `XLEN'd4;
    assign pcF_o   = pcF;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pcF <= `RESET_PC;
            fd  <= '0;
        end else begin
            if (!hazardCtl_i.stallF) begin
                pcF <= pcNextF;
            end
            if (hazardCtl_i.flushD) begin
                fd <= '0;  // Zero word decodes as a bubble
            end else if (!hazardCtl_i.stallD) begin
                fd.instr <= instrF_i;
                fd.pc    <= pcF;
            end
        end
    end

    // Decode
    riscvRegFile regFile_i (
        .clk       (clk),
        .arstN_i   (arstN_i),
        .rs1Addr_i (fd.instr[19:15]),
        .rs2Addr_i (fd.instr[24:20]),
        .rdAddr_i  (mw.rd),
        .rdData_i  (resultW),
        .we_i      (stageCtl_i.regWriteW),
        .rs1Data_o (rd1D),
        .rs2Data_o (rd2D)
    );

    always_comb begin
        deNext.rd1 = rd1D;
        deNext.rd2 = rd2D;
        deNext.pc  = fd.pc;
        deNext.rs1 = fd.instr[19:15];
        deNext.rs2 = fd.instr[24:20];
        deNext.rd  = fd.instr[11:7];
        case (stageCtl_i.immSrcD)
            riscvPipe_pkg::IMM_S:
                deNext.imm = {{(`XLEN-12){fd.instr[31]}}, fd.instr[31:25], fd.instr[11:7]};
            riscvPipe_pkg::IMM_B:
                deNext.imm = {{(`XLEN-12){fd.instr[31]}}, fd.instr[7], fd.instr[30:25],
                              fd.instr[11:8], 1'b0};
            riscvPipe_pkg::IMM_J:
                deNext.imm = {{(`XLEN-20){fd.instr[31]}}, fd.instr[19:12], fd.instr[20],
                              fd.instr[30:21], 1'b0};
            default:
                deNext.imm = {{(`XLEN-12){fd.instr[31]}}, fd.instr[31:20]};
        endcase
    end

    always_comb begin
        decodeInfo_o.opcode   = riscvPipe_pkg::opcode_e'(fd.instr[6:0]);
        decodeInfo_o.funct3   = fd.instr[14:12];
        decodeInfo_o.funct7b5 = fd.instr[30];
        decodeInfo_o.rs1D     = deNext.rs1;
        decodeInfo_o.rs2D     = deNext.rs2;
        decodeInfo_o.rs1E     = de.rs1;
        decodeInfo_o.rs2E     = de.rs2;
        decodeInfo_o.rdE      = de.rd;
        decodeInfo_o.rdM      = em.rd;
        decodeInfo_o.rdW      = mw.rd;
    end

    // Execute
    assign fwdValueM  = (stageCtl_i.resultSrcM == riscvPipe_pkg::RES_PC4) ? em.pcPlus4
                                                                            : em.aluResult;
    assign srcAE      = fwdMux(hazardCtl_i.forwardAE, de.rd1, resultW, fwdValueM);
    assign writeDataE = fwdMux(hazardCtl_i.forwardBE, de.rd2, resultW, fwdValueM);
    assign srcBE      = stageCtl_i.aluSrcE ? de.imm : writeDataE;
    assign pcTargetE  = de.pc + de.imm;

    always_comb begin
        case (stageCtl_i.aluOpE)
            riscvPipe_pkg::ALU_SUB: aluResultE = srcAE - srcBE;
            riscvPipe_pkg::ALU_AND: aluResultE = srcAE & srcBE;
            riscvPipe_pkg::ALU_OR:  aluResultE = srcAE | srcBE;
            riscvPipe_pkg::ALU_SLT: aluResultE = {{(`XLEN-1){1'b0}},
                                                  $signed(srcAE) < $signed(srcBE)};
            default:                aluResultE = srcAE + srcBE;
        endcase
    end

    // Not-taken prediction, so any redirect is a mispredict
    assign takenE        = stageCtl_i.branchE &&
                           ((srcAE == writeDataE) ^ stageCtl_i.branchNeE);
    assign mispredictE_o = takenE || stageCtl_i.jumpE;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            de <= '0;
            em <= '0;
            mw <= '0;
        end else begin
            de <= hazardCtl_i.flushE ? '0 : deNext;
            em.aluResult <= aluResultE;
            em.data      <= writeDataE;
            em.pcPlus4   <= de.pc + `XLEN'd4;
            em.rd        <= de.rd;
            mw.aluResult <= em.aluResult;
            mw.data      <= readDataM_i;  // Memory answers in the same cycle
            mw.pcPlus4   <= em.pcPlus4;
            mw.rd        <= em.rd;
        end
    end

    // Memory
    assign aluResultM_o = em.aluResult;
    assign writeDataM_o = em.data;

    // Writeback
    always_comb begin
        case (stageCtl_i.resultSrcW)
            riscvPipe_pkg::RES_MEM: resultW = mw.data;
            riscvPipe_pkg::RES_PC4: resultW = mw.pcPlus4;
            default:                resultW = mw.aluResult;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/riscvPipe.sv
/*
 * Five-stage RV32I pipeline top
 * Controller plus datapath, memories sit outside
 */

`default_nettype none

`include "riscvPipe_macros.svh"

module riscvPipe (
    input  wire logic              clk,
    input  wire logic              arstN_i,
    output logic     [`XLEN-1:0]   pcF_o,
    input  wire logic [`XLEN-1:0]  instrF_i,
    input  wire logic              readyF_i,      // Instruction memory has data
    output logic                   readEnableF_o,
    output logic                   memWriteM_o,
    output logic     [`XLEN-1:0]   aluResultM_o,  // Data address
    output logic     [`XLEN-1:0]   writeDataM_o,
    input  wire logic [`XLEN-1:0]  readDataM_i
);

    riscvPipe_pkg::decodeInfo_t decodeInfo;
    riscvPipe_pkg::stageCtl_t   stageCtl;
    riscvPipe_pkg::hazardCtl_t  hazardCtl;
    logic                       mispredictE;

    assign readEnableF_o = !hazardCtl.stallF;
    assign memWriteM_o   = stageCtl.memWriteM;

    riscvPipeController controller_i (
        .clk           (clk),
        .arstN_i       (arstN_i),
        .decodeInfo_i  (decodeInfo),
        .mispredictE_i (mispredictE),
        .readyF_i      (readyF_i),
        .stageCtl_o    (stageCtl),
        .hazardCtl_o   (hazardCtl)
    );

    riscvPipeDatapath datapath_i (
        .clk           (clk),
        .arstN_i       (arstN_i),
        .instrF_i      (instrF_i),
        .readDataM_i   (readDataM_i),
        .stageCtl_i    (stageCtl),
        .hazardCtl_i   (hazardCtl),
        .pcF_o         (pcF_o),
        .decodeInfo_o  (decodeInfo),
        .mispredictE_o (mispredictE),
        .aluResultM_o  (aluResultM_o),
        .writeDataM_o  (writeDataM_o)
    );

endmodule

`default_nettype wire

// File: bench/riscvPipe_asserts.sv
/*
 * Pipeline top assertions
 * Store quiet in reset, PC held on fetch stall, PC word aligned
 */

`default_nettype none

`include "riscvPipe_macros.svh"

module riscvPipe_asserts (
    input wire logic             clk,
    input wire logic             arstN_i,
    input wire logic             memWriteM_o,
    input wire logic             readEnableF_o,
    input wire logic             mispredictE_i,
    input wire logic [`XLEN-1:0] pcF_o
);

    timeunit 1ns;
    timeprecision 1ps;

    noStoreInReset: assert property (@(posedge clk) !arstN_i |-> !memWriteM_o)
        else $error("store seen while reset is asserted");

    // Fetch stall holds the PC unless execute redirects it
    pcHeldOnStall: assert property (@(posedge clk) disable iff (!arstN_i)
        (!readEnableF_o && !mispredictE_i) |=> $stable(pcF_o))
        else $error("PC moved during a fetch stall");

    pcAligned: assert property (@(posedge clk) disable iff (!arstN_i) pcF_o[1:0] == 2'b00)
        else $error("PC is not word aligned");

endmodule

bind riscvPipe riscvPipe_asserts asserts_i (
    .clk           (clk),
    .arstN_i       (arstN_i),
    .memWriteM_o   (memWriteM_o),
    .readEnableF_o (readEnableF_o),
    .mispredictE_i (mispredictE),
    .pcF_o         (pcF_o)
);

`default_nettype wire

// File: bench/riscvPipe_tb.sv
/*
 * Testbench for the five-stage RV32I pipeline
 * Runs the programs from the cases file against instruction and data
 * memory models with random fetch stalls and checks every store
 */

`default_nettype none

`include "riscvPipe_macros.svh"

module riscvPipe_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int BUDGET     = 340;  // Cycles to see all expected stores
    localparam int DRAIN      = 40;   // Extra cycles to catch late stores

    localparam logic [`XLEN-1:0] NOT_READY_WORD = 32'hFE00_2E23;  // sw x0 to address -4

    typedef struct packed {
        logic [`XLEN-1:0] addr;
        logic [`XLEN-1:0] data;
    } store_t;

    logic             clk;
    logic             arstN;
    logic [`XLEN-1:0] pcF;
    logic [`XLEN-1:0] instrF;
    logic             readyF;
    logic             readEnableF;
    logic             memWriteM;
    logic [`XLEN-1:0] aluResultM;
    logic [`XLEN-1:0] writeDataM;
    logic [`XLEN-1:0] readDataM;

    logic [`XLEN-1:0] imem [IMEM_WORDS];
    logic [`XLEN-1:0] dmem [DMEM_WORDS];

    string            testName [$];
    int               progStart [$];
    int               progLen [$];
    int               expStart [$];
    int               expCnt [$];
    logic [`XLEN-1:0] progWords [$];
    store_t           expStores [$];

    int curTest;
    int storeIdx;
    int testErrors;
    int passCount;
    int failCount;
    bit running;

    riscvPipe dut_i (
        .clk           (clk),
        .arstN_i       (arstN),
        .pcF_o         (pcF),
        .instrF_i      (instrF),
        .readyF_i      (readyF),
        .readEnableF_o (readEnableF),
        .memWriteM_o   (memWriteM),
        .aluResultM_o  (aluResultM),
        .writeDataM_o  (writeDataM),
        .readDataM_i   (readDataM)
    );

    // Both memories answer combinationally
    assign instrF    = readyF ? imem[pcF[9:2]] : NOT_READY_WORD;  // Junk while not ready
    assign readDataM = dmem[aluResultM[9:2]];

    always #20 clk = ~clk;

    // Mid-cycle sampling, outputs are settled here
    always @(negedge clk) begin
        if (running && arstN && memWriteM) begin
            if (storeIdx >= expCnt[curTest]) begin
                $display("test %s: unexpected extra store of %h to address %h",
                         testName[curTest], writeDataM, aluResultM);
                testErrors++;
            end else begin
                if ((expStores[expStart[curTest] + storeIdx].addr != aluResultM) ||
                    (expStores[expStart[curTest] + storeIdx].data != writeDataM)) begin
                    $display("mismatch %s store %0d: expected %h at %h, actual %h at %h",
                             testName[curTest], storeIdx,
                             expStores[expStart[curTest] + storeIdx].data,
                             expStores[expStart[curTest] + storeIdx].addr,
                             writeDataM, aluResultM);
                    testErrors++;
                end
            end
            storeIdx++;
            dmem[aluResultM[9:2]] = writeDataM;
        end
    end

    task automatic readCases();
        int               fd;
        string            line;
        string            name;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        fd = $fopen("bench/riscvPipe_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the cases file");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") begin
                continue;
            end
            if ($sscanf(line, "test %s", name) == 1) begin
                testName.push_back(name);
                progStart.push_back(progWords.size());
                progLen.push_back(0);
                expStart.push_back(expStores.size());
                expCnt.push_back(0);
            end else if ($sscanf(line, "s %h %h", a, b) == 2) begin
                expStores.push_back('{addr: a, data: b});
                expCnt[expCnt.size() - 1]++;
            end else if ($sscanf(line, "i %h", a) == 1) begin
                progWords.push_back(a);
                progLen[progLen.size() - 1]++;
            end
        end
        $fclose(fd);
    endtask

    task automatic stepCycle();
        @(posedge clk);
        #2 readyF = (($urandom % 4) != 0);  // Fetch stalls on about a quarter
    endtask

    task automatic runTest(input int t);
        int cycles;
        // Fill decodes as addi x0 with the word index as immediate
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {i[11:0], 20'h00013};
        end
        for (int i = 0; i < progLen[t]; i++) begin
            imem[i] = progWords[progStart[t] + i];
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = 32'hD000_0000 | (i * 4);
        end
        curTest    = t;
        storeIdx   = 0;
        testErrors = 0;
        @(posedge clk);
        #2 arstN = 1'b0;
        readyF = 1'b1;
        repeat (4) @(posedge clk);
        if (!readEnableF) begin
            $display("test %s: readEnableF_o is low during reset", testName[t]);
            testErrors++;
        end
        #2 arstN = 1'b1;
        running = 1'b1;
        cycles  = 0;
        while (storeIdx < expCnt[t] && cycles < BUDGET) begin
            stepCycle();
            cycles++;
        end
        if (storeIdx < expCnt[t]) begin
            $display("test %s: only %0d of %0d stores seen before the cycle budget ran out",
                     testName[t], storeIdx, expCnt[t]);
            testErrors++;
        end
        repeat (DRAIN) stepCycle();
        running = 1'b0;
        if (testErrors == 0) begin
            $display("test %s passed with %0d stores", testName[t], expCnt[t]);
            passCount++;
        end else begin
            $display("test %s failed with %0d errors", testName[t], testErrors);
            failCount++;
        end
    endtask

    initial begin
        longint watchdogNs;
        clk       = 1'b0;
        arstN     = 1'b0;
        readyF    = 1'b1;
        running   = 1'b0;
        passCount = 0;
        failCount = 0;
        void'($urandom(57));
        readCases();
        if (testName.size() == 0) begin
            $display("no test cases were loaded");
        end
        watchdogNs = longint'(testName.size()) * 400 * 40;
        fork
            begin
                #(watchdogNs);
                $display("timeout: the run exceeded its time limit");
                $display("TESTBENCH FAILED");
                $finish;
            end
        join_none
        for (int t = 0; t < testName.size(); t++) begin
            runTest(t);
        end
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0 && testName.size() > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/riscvPipe_cases.txt
# test <name> starts a test; i <word> is an instruction from address 0 upward
# s <addr> <data> is an expected store in program order, all values hex
test alu_fwd
i 00500093
i 00308113
i 002081B3
i 40118233
i 003272B3
i 0012E333
i 0060A3B3
i FFD00413
i 001424B3
i 00902A23
i 00302023
i 00402223
i 00502423
i 00602623
i 00702823
i 0000006F
s 00000014 00000001
s 00000000 0000000D
s 00000004 00000008
s 00000008 00000008
s 0000000C 0000000D
s 00000010 00000001
test load_use
i 06400093
i 02102023
i 02002103
i 001101B3
i 02302223
i 02402203
i 02402423
i 04002283
i 00128313
i 02602623
i 0000006F
s 00000020 00000064
s 00000024 000000C8
s 00000028 000000C8
s 0000002C D0000041
test branches
i 00700093
i 00700113
i 00208663
i 00102023
i 00102223
i 00209463
i 00202423
i 00900193
i 00309463
i 00102623
i 00302823
i 00308463
i 00102A23
i 0000006F
s 00000008 00000007
s 00000010 00000009
s 00000014 00000007
test jal_link
i 00100093
i 00C002EF
i 00102023
i 06300093
i 00502223
i 00102423
i 0080006F
i 00102623
i 004003EF
i 00702823
i 0000006F
s 00000004 00000008
s 00000008 00000001
s 00000010 00000024
test x0_discard
i 03700013
i 00300093
i 00108033
i 00002023
i 00100133
i 00202223
i 0000006F
s 00000000 00000000
s 00000004 00000003

// File: all.f
+incdir+logic
logic/riscvPipe_pkg.sv
logic/riscvRegFile.sv
logic/riscvPipeController.sv
logic/riscvPipeDatapath.sv
logic/riscvPipe.sv
bench/riscvPipe_asserts.sv
bench/riscvPipe_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module riscvPipe_tb -f all.f -o simv
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0
